// File: hw/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Datapath geometry
`define CPU_XLEN        32
`define CPU_NREGS       32
`define CPU_RESET_PC    32'h0000_0000
`define CPU_LINK_REG    5'd31

// Primary opcodes
`define CPU_OP_SPECIAL  6'b000000
`define CPU_OP_J        6'b000010
`define CPU_OP_JAL      6'b000011
`define CPU_OP_BEQ      6'b000100
`define CPU_OP_BNE      6'b000101
`define CPU_OP_ADDIU    6'b001001
`define CPU_OP_SLTI     6'b001010
`define CPU_OP_ANDI     6'b001100
`define CPU_OP_ORI      6'b001101
`define CPU_OP_XORI     6'b001110
`define CPU_OP_LUI      6'b001111
`define CPU_OP_LW       6'b100011
`define CPU_OP_SW       6'b101011

// Function codes under SPECIAL
`define CPU_FN_SLL      6'b000000
`define CPU_FN_SRL      6'b000010
`define CPU_FN_SRA      6'b000011
`define CPU_FN_JR       6'b001000
`define CPU_FN_ADDU     6'b100001
`define CPU_FN_SUBU     6'b100011
`define CPU_FN_AND      6'b100100
`define CPU_FN_OR       6'b100101
`define CPU_FN_XOR      6'b100110
`define CPU_FN_NOR      6'b100111
`define CPU_FN_SLT      6'b101010
`define CPU_FN_SLTU     6'b101011

`endif

// File: hw/cpu_pkg.sv
`default_nettype none

`include "cpu_macros.svh"

package cpu_pkg;

    typedef logic [`CPU_XLEN-1:0]          word_t;
    typedef logic [$clog2(`CPU_NREGS)-1:0] reg_addr_t;
    typedef logic [`CPU_XLEN/8-1:0]        strb_t;
    typedef logic [4:0]                    shamt_t;

    typedef enum logic [3:0] {
        S_RESET,
        S_FETCH,
        S_INST_WAIT,
        S_DECODE,
        S_EXECUTE,
        S_WRITEBACK,
        S_STORE,
        S_LOAD,
        S_READ_WAIT
    } cpu_state_e;

    // Steers the FSM path after execute
    typedef enum logic [2:0] {
        CLS_NOP,
        CLS_ALU,
        CLS_BRANCH,
        CLS_JUMP,
        CLS_JUMP_LINK,
        CLS_LOAD,
        CLS_STORE
    } inst_class_e;

    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR, NOR, SLT, SLTU, SLL, SRL, SRA, LUI
    } alu_op_e;

    typedef struct packed {
        alu_op_e   alu_op;
        logic      use_imm;
        logic      imm_zero_ext;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        shamt_t    shamt;
        logic      reg_write;
        logic      wb_dest;      // 1 writes rt, 0 writes rd
        logic      wb_link;
        logic      wb_load;
        logic      branch;
        logic      branch_ne;
        logic      jump;
        logic      jump_reg;
    } decoded_t;

    typedef struct packed {
        word_t addr;
        word_t wdata;
        strb_t wstrb;
    } mem_req_t;

    typedef struct packed {
        word_t cycles;
        word_t fetches;
        word_t mem_reqs;
    } perf_cnt_t;

endpackage

`default_nettype wire

// File: hw/cpu_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module cpu_alu
    import cpu_pkg::*;
(
    input  word_t   a,
    input  word_t   b,
    input  shamt_t  shamt,
    input  alu_op_e op,
    output word_t   result,
    output logic    zero
);

    always_comb begin
        case (op)
            ADD:     result = a + b;
            SUB:     result = a - b;
            AND:     result = a & b;
            OR:      result = a | b;
            XOR:     result = a ^ b;
            NOR:     result = ~(a | b);
            SLT:     result = word_t'($signed(a) < $signed(b));
            SLTU:    result = word_t'(a < b);
            // Shifts act on the rt operand
            SLL:     result = b << shamt;
            SRL:     result = b >> shamt;
            SRA:     result = word_t'($signed(b) >>> shamt);
            LUI:     result = {b[`CPU_XLEN/2-1:0], {(`CPU_XLEN/2){1'b0}}};
            default: result = a + b;
        endcase
    end

    // Branch compare uses SUB
    assign zero = (result == '0);

endmodule

`default_nettype wire

// File: hw/cpu_reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module cpu_reg_file
    import cpu_pkg::*;
(
    input  logic      clk,
    input  reg_addr_t raddr1,
    input  reg_addr_t raddr2,
    input  reg_addr_t waddr,
    input  logic      wen,
    input  word_t     wdata,
    output word_t     rdata1,
    output word_t     rdata2
);

    word_t regs [`CPU_NREGS];

    always_ff @(posedge clk) begin
        if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // Register zero is never written, so it reads as a constant
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// File: hw/cpu_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module cpu_decode
    import cpu_pkg::*;
(
    input  word_t       instr,
    output decoded_t    decoded,
    output inst_class_e inst_class
);

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    always_comb begin
        decoded       = '0;
        decoded.rs    = instr[25:21];
        decoded.rt    = instr[20:16];
        decoded.rd    = instr[15:11];
        decoded.shamt = instr[10:6];
        inst_class    = CLS_NOP;

        case (opcode)
            `CPU_OP_SPECIAL: begin
                inst_class        = CLS_ALU;
                decoded.reg_write = 1'b1;
                case (funct)
                    `CPU_FN_SLL:  decoded.alu_op = SLL;
                    `CPU_FN_SRL:  decoded.alu_op = SRL;
                    `CPU_FN_SRA:  decoded.alu_op = SRA;
                    `CPU_FN_ADDU: decoded.alu_op = ADD;
                    `CPU_FN_SUBU: decoded.alu_op = SUB;
                    `CPU_FN_AND:  decoded.alu_op = AND;
                    `CPU_FN_OR:   decoded.alu_op = OR;
                    `CPU_FN_XOR:  decoded.alu_op = XOR;
                    `CPU_FN_NOR:  decoded.alu_op = NOR;
                    `CPU_FN_SLT:  decoded.alu_op = SLT;
                    `CPU_FN_SLTU: decoded.alu_op = SLTU;
                    `CPU_FN_JR: begin
                        inst_class        = CLS_JUMP;
                        decoded.reg_write = 1'b0;
                        decoded.jump      = 1'b1;
                        decoded.jump_reg  = 1'b1;
                    end
                    default: begin
                        inst_class        = CLS_NOP;
                        decoded.reg_write = 1'b0;
                    end
                endcase
            end
            `CPU_OP_ADDIU, `CPU_OP_SLTI, `CPU_OP_ANDI,
            `CPU_OP_ORI, `CPU_OP_XORI, `CPU_OP_LUI: begin
                inst_class           = CLS_ALU;
                decoded.use_imm      = 1'b1;
                decoded.reg_write    = 1'b1;
                decoded.wb_dest      = 1'b1;
                // andi, ori, xori and lui all have opcode bit 2 set
                decoded.imm_zero_ext = opcode[2];
                case (opcode)
                    `CPU_OP_SLTI: decoded.alu_op = SLT;
                    `CPU_OP_ANDI: decoded.alu_op = AND;
                    `CPU_OP_ORI:  decoded.alu_op = OR;
                    `CPU_OP_XORI: decoded.alu_op = XOR;
                    `CPU_OP_LUI:  decoded.alu_op = LUI;
                    default:      decoded.alu_op = ADD;
                endcase
            end
            `CPU_OP_LW: begin
                inst_class        = CLS_LOAD;
                decoded.use_imm   = 1'b1;
                decoded.reg_write = 1'b1;
                decoded.wb_dest   = 1'b1;
                decoded.wb_load   = 1'b1;
            end
            `CPU_OP_SW: begin
                inst_class      = CLS_STORE;
                decoded.use_imm = 1'b1;
            end
            `CPU_OP_BEQ, `CPU_OP_BNE: begin
                inst_class        = CLS_BRANCH;
                decoded.alu_op    = SUB;
                decoded.branch    = 1'b1;
                decoded.branch_ne = opcode[0];
            end
            `CPU_OP_J: begin
                inst_class   = CLS_JUMP;
                decoded.jump = 1'b1;
            end
            `CPU_OP_JAL: begin
                inst_class        = CLS_JUMP_LINK;
                decoded.jump      = 1'b1;
                decoded.wb_link   = 1'b1;
                decoded.reg_write = 1'b1;
            end
            default: inst_class = CLS_NOP;
        endcase

        // The all-zero word is sll $0 and retires straight from decode
        if (instr == '0) begin
            inst_class        = CLS_NOP;
            decoded.reg_write = 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: hw/cpu_control.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_control
    import cpu_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        inst_req_ready,
    input  logic        inst_valid,
    input  logic        mem_req_ready,
    input  logic        read_valid,
    input  inst_class_e inst_class,
    output cpu_state_e  state,
    output logic        inst_req_valid,
    output logic        inst_ready,
    output logic        mem_write,
    output logic        mem_read,
    output logic        read_ready,
    output logic        fetch_done,
    output logic        decode_step,
    output logic        writeback_step,
    output logic        load_done
);

    cpu_state_e state_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_RESET;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            S_RESET:     state_next = S_FETCH;
            S_FETCH: begin
                if (inst_req_ready) begin
                    state_next = S_INST_WAIT;
                end
            end
            S_INST_WAIT: begin
                if (inst_valid) begin
                    state_next = S_DECODE;
                end
            end
            // Zero word and unknown encodings retire here
            S_DECODE:    state_next = (inst_class == CLS_NOP) ? S_FETCH : S_EXECUTE;
            S_EXECUTE: begin
                case (inst_class)
                    CLS_ALU, CLS_JUMP_LINK: state_next = S_WRITEBACK;
                    CLS_STORE:              state_next = S_STORE;
                    CLS_LOAD:               state_next = S_LOAD;
                    default:                state_next = S_FETCH;
                endcase
            end
            S_WRITEBACK: state_next = S_FETCH;
            S_STORE: begin
                if (mem_req_ready) begin
                    state_next = S_FETCH;
                end
            end
            S_LOAD: begin
                if (mem_req_ready) begin
                    state_next = S_READ_WAIT;
                end
            end
            S_READ_WAIT: begin
                if (read_valid) begin
                    state_next = S_WRITEBACK;
                end
            end
            default:     state_next = S_RESET;
        endcase
    end

    // Handshakes follow the state alone, so they hold while stalled
    assign inst_req_valid = (state == S_FETCH);
    assign inst_ready     = (state == S_INST_WAIT);
    assign mem_write      = (state == S_STORE);
    assign mem_read       = (state == S_LOAD);
    assign read_ready     = (state == S_READ_WAIT);

    assign fetch_done     = inst_ready & inst_valid;
    assign decode_step    = (state == S_DECODE);
    assign writeback_step = (state == S_WRITEBACK);
    assign load_done      = read_ready & read_valid;

    property p_valid_hold(logic valid, logic ready);
        @(posedge clk) disable iff (rst) valid && !ready |=> valid;
    endproperty

    // Response valids from the memory side stay up until accepted
    a_inst_valid_hold: assert property (p_valid_hold(inst_valid, inst_ready));
    a_read_valid_hold: assert property (p_valid_hold(read_valid, read_ready));

    a_state_legal: assert property (@(posedge clk) disable iff (rst)
        state inside {S_RESET, S_FETCH, S_INST_WAIT, S_DECODE, S_EXECUTE,
                      S_WRITEBACK, S_STORE, S_LOAD, S_READ_WAIT});

endmodule

`default_nettype wire

// File: hw/cpu_datapath.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module cpu_datapath
    import cpu_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  word_t    instruction,
    input  word_t    read_data,
    input  decoded_t decoded,
    input  logic     fetch_done,
    input  logic     decode_step,
    input  logic     writeback_step,
    input  logic     load_done,
    output word_t    instr,
    output word_t    pc,
    output mem_req_t mem_req
);

    word_t     load_q;
    word_t     link_addr;
    word_t     imm_ext;
    word_t     rdata1;
    word_t     rdata2;
    word_t     alu_b;
    word_t     alu_result;
    word_t     wb_data;
    word_t     pc_plus4;
    word_t     branch_target;
    word_t     jump_target;
    reg_addr_t waddr;
    logic      alu_zero;
    logic      branch_taken;
    logic      mem_op;

    always_ff @(posedge clk) begin
        if (fetch_done) begin
            instr <= instruction;
        end
        if (load_done) begin
            load_q <= read_data;
        end
        // Return address of jal, taken before the PC moves on
        if (decode_step) begin
            link_addr <= pc + 32'd8;
        end
    end

    assign imm_ext = decoded.imm_zero_ext ? {16'b0, instr[15:0]}
                                          : {{16{instr[15]}}, instr[15:0]};

    assign pc_plus4      = pc + 32'd4;
    assign branch_target = pc_plus4 + {imm_ext[29:0], 2'b00};
    assign jump_target   = decoded.jump_reg ? rdata1
                                            : {pc_plus4[31:28], instr[25:0], 2'b00};

    assign alu_b        = decoded.use_imm ? imm_ext : rdata2;
    assign branch_taken = decoded.branch & (alu_zero ^ decoded.branch_ne);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `CPU_RESET_PC;
        end else if (decode_step) begin
            if (branch_taken) begin
                pc <= branch_target;
            end else if (decoded.jump) begin
                pc <= jump_target;
            end else begin
                pc <= pc_plus4;
            end
        end
    end

    assign waddr = decoded.wb_link ? `CPU_LINK_REG
                 : decoded.wb_dest ? decoded.rt : decoded.rd;

    assign wb_data = decoded.wb_load ? load_q
                   : decoded.wb_link ? link_addr : alu_result;

    cpu_alu u_alu (
        .a      (rdata1),
        .b      (alu_b),
        .shamt  (decoded.shamt),
        .op     (decoded.alu_op),
        .result (alu_result),
        .zero   (alu_zero)
    );

    cpu_reg_file u_reg_file (
        .clk    (clk),
        .raddr1 (decoded.rs),
        .raddr2 (decoded.rt),
        .waddr  (waddr),
        .wen    (writeback_step & decoded.reg_write),
        .wdata  (wb_data),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    // Word accesses only
    assign mem_req.addr  = alu_result;
    assign mem_req.wdata = rdata2;
    assign mem_req.wstrb = '1;

    // Stores are the only class with an immediate operand and no write-back
    assign mem_op = decoded.wb_load | (decoded.use_imm & ~decoded.reg_write);

    a_word_aligned: assert property (@(posedge clk) disable iff (rst)
        decode_step && mem_op |-> mem_req.addr[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: hw/cpu_perf_counters.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_perf_counters
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      inst_ready,
    input  logic      inst_valid,
    input  logic      mem_req_ready,
    input  logic      mem_write,
    input  logic      mem_read,
    output perf_cnt_t perf
);

    logic fetch_hit;
    logic mem_hit;

    assign fetch_hit = inst_ready & inst_valid;
    assign mem_hit   = (mem_write | mem_read) & mem_req_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            perf <= '0;
        end else begin
            perf.cycles <= perf.cycles + 1'b1;
            if (fetch_hit) begin
                perf.fetches <= perf.fetches + 1'b1;
            end
            if (mem_hit) begin
                perf.mem_reqs <= perf.mem_reqs + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    // Instruction request and response
    output word_t     pc,
    output logic      inst_req_valid,
    input  logic      inst_req_ready,
    input  word_t     instruction,
    input  logic      inst_valid,
    output logic      inst_ready,

    // Data memory request and read response
    output mem_req_t  mem_req,
    output logic      mem_write,
    output logic      mem_read,
    input  logic      mem_req_ready,
    input  word_t     read_data,
    input  logic      read_valid,
    output logic      read_ready,

    output perf_cnt_t perf
);

    word_t       instr;
    decoded_t    decoded;
    inst_class_e inst_class;
    logic        fetch_done;
    logic        decode_step;
    logic        writeback_step;
    logic        load_done;

    cpu_control u_control (
        .clk            (clk),
        .rst            (rst),
        .inst_req_ready (inst_req_ready),
        .inst_valid     (inst_valid),
        .mem_req_ready  (mem_req_ready),
        .read_valid     (read_valid),
        .inst_class     (inst_class),
        .state          (),
        .inst_req_valid (inst_req_valid),
        .inst_ready     (inst_ready),
        .mem_write      (mem_write),
        .mem_read       (mem_read),
        .read_ready     (read_ready),
        .fetch_done     (fetch_done),
        .decode_step    (decode_step),
        .writeback_step (writeback_step),
        .load_done      (load_done)
    );

    cpu_decode u_decode (
        .instr      (instr),
        .decoded    (decoded),
        .inst_class (inst_class)
    );

    cpu_datapath u_datapath (
        .clk            (clk),
        .rst            (rst),
        .instruction    (instruction),
        .read_data      (read_data),
        .decoded        (decoded),
        .fetch_done     (fetch_done),
        .decode_step    (decode_step),
        .writeback_step (writeback_step),
        .load_done      (load_done),
        .instr          (instr),
        .pc             (pc),
        .mem_req        (mem_req)
    );

    cpu_perf_counters u_perf (
        .clk           (clk),
        .rst           (rst),
        .inst_ready    (inst_ready),
        .inst_valid    (inst_valid),
        .mem_req_ready (mem_req_ready),
        .mem_write     (mem_write),
        .mem_read      (mem_read),
        .perf          (perf)
    );

endmodule

`default_nettype wire

// File: testbench/tb_cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_top
    import cpu_pkg::*;
();

    localparam int CLK_PERIOD      = 20;
    localparam int RESET_CYCLES    = 8;
    localparam int STIM_WORDS      = 512;
    localparam int CHECK_BASE      = 256;
    localparam int DMEM_WORDS      = 256;
    localparam int CYCLES_PER_WORD = 200;

    logic      clk;
    logic      rst;
    word_t     pc;
    logic      inst_req_valid;
    logic      inst_req_ready;
    word_t     instruction;
    logic      inst_valid;
    logic      inst_ready;
    mem_req_t  mem_req;
    logic      mem_write;
    logic      mem_read;
    logic      mem_req_ready;
    word_t     read_data;
    logic      read_valid;
    logic      read_ready;
    perf_cnt_t perf;

    // Program image, then the check block at CHECK_BASE
    word_t  stim [0:STIM_WORDS-1];
    word_t  dmem [0:DMEM_WORDS-1];
    word_t  fetch_q [$];
    word_t  load_q [$];
    integer seed;
    int     prog_len;
    int     store_count;
    int     store_idx;
    int     cycles_seen;
    logic   final_seen;
    logic   inst_sent;
    logic   read_sent;

    cpu_top cpu_top_i (
        .clk            (clk),
        .rst            (rst),
        .pc             (pc),
        .inst_req_valid (inst_req_valid),
        .inst_req_ready (inst_req_ready),
        .instruction    (instruction),
        .inst_valid     (inst_valid),
        .inst_ready     (inst_ready),
        .mem_req        (mem_req),
        .mem_write      (mem_write),
        .mem_read       (mem_read),
        .mem_req_ready  (mem_req_ready),
        .read_data      (read_data),
        .read_valid     (read_valid),
        .read_ready     (read_ready),
        .perf           (perf)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Roughly one stall in four
    function automatic logic random_ready();
        return ($random(seed) & 3) != 0;
    endfunction

    function automatic word_t program_word(word_t addr);
        word_t data;
        data = '0;
        if ((addr >> 2) < prog_len) begin
            data = stim[addr[10:2]];
        end
        return data;
    endfunction

    task automatic check_value(string name, word_t expected, word_t actual);
        if (expected !== actual) begin
            $display("ERROR %s: expected %08h, actual %08h", name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "check failed");
        end
    endtask

    task automatic fail_run(string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "run stopped");
    endtask

    // Stores must arrive in file order with full strobes
    task automatic accept_store();
        int rec;
        rec = CHECK_BASE + 2 + 2 * store_idx;
        if (store_idx >= store_count) begin
            fail_run($sformatf("Unexpected store to address %08h", mem_req.addr));
        end else begin
            check_value($sformatf("store %0d address", store_idx), stim[rec], mem_req.addr);
            check_value($sformatf("store %0d data", store_idx), stim[rec + 1], mem_req.wdata);
            check_value($sformatf("store %0d wstrb", store_idx), 32'h0000_000F,
                        word_t'(mem_req.wstrb));
            dmem[mem_req.addr[9:2]] = mem_req.wdata;
            store_idx = store_idx + 1;
            if (store_idx == store_count) begin
                final_seen = 1'b1;
            end
        end
    endtask

    // Called on each falling edge; transfers land on the next rising edge
    task automatic step_models();
        // Instruction response
        if (inst_sent) begin
            inst_valid = 1'b0;
            inst_sent  = 1'b0;
        end
        if (!inst_valid && fetch_q.size() != 0 && random_ready()) begin
            instruction = program_word(fetch_q.pop_front());
            inst_valid  = 1'b1;
        end
        inst_sent = inst_valid & inst_ready;

        // Instruction request
        inst_req_ready = random_ready();
        if (inst_req_valid && inst_req_ready) begin
            fetch_q.push_back(pc);
        end

        // Read response
        if (read_sent) begin
            read_valid = 1'b0;
            read_sent  = 1'b0;
        end
        if (!read_valid && load_q.size() != 0 && random_ready()) begin
            read_data  = dmem[load_q.pop_front() >> 2];
            read_valid = 1'b1;
        end
        read_sent = read_valid & read_ready;

        // Memory request
        mem_req_ready = random_ready();
        if (mem_req_ready && mem_write) begin
            accept_store();
        end
        if (mem_req_ready && mem_read) begin
            load_q.push_back(mem_req.addr);
        end
    endtask

    initial begin
        seed           = 89706;
        clk            = 1'b0;
        rst            = 1'b1;
        inst_req_ready = 1'b0;
        instruction    = '0;
        inst_valid     = 1'b0;
        mem_req_ready  = 1'b0;
        read_data      = '0;
        read_valid     = 1'b0;
        store_idx      = 0;
        cycles_seen    = 0;
        final_seen     = 1'b0;
        inst_sent      = 1'b0;
        read_sent      = 1'b0;

        $readmemh("testbench/cpu_stimulus.mem", stim);
        prog_len    = int'(stim[CHECK_BASE]);
        store_count = int'(stim[CHECK_BASE + 1]);
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = 32'hA500_0000 | word_t'(i << 2);
        end

        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;

        // Still the reset state until the next rising edge
        check_value("reset inst_req_valid", '0, word_t'(inst_req_valid));
        check_value("reset inst_ready", '0, word_t'(inst_ready));
        check_value("reset mem_write", '0, word_t'(mem_write));
        check_value("reset mem_read", '0, word_t'(mem_read));
        check_value("reset read_ready", '0, word_t'(read_ready));
        check_value("reset pc", '0, pc);
        check_value("reset cycles", '0, perf.cycles);
        check_value("reset fetches", '0, perf.fetches);
        check_value("reset mem_reqs", '0, perf.mem_reqs);

        while (!final_seen) begin
            @(negedge clk);
            cycles_seen = cycles_seen + 1;
            step_models();
        end

        // Counters show the final store one cycle after it is taken
        @(negedge clk);
        cycles_seen = cycles_seen + 1;
        check_value("fetch count", stim[CHECK_BASE + 2 + 2 * store_count], perf.fetches);
        check_value("memory request count", stim[CHECK_BASE + 3 + 2 * store_count],
                    perf.mem_reqs);
        check_value("cycle count", word_t'(cycles_seen), perf.cycles);
        $display("Simulation completed successfully");
        $finish;
    end

    // Watchdog scaled by program length
    initial begin
        @(negedge rst);
        repeat (CYCLES_PER_WORD * prog_len) @(posedge clk);
        $display("Timeout: the final store did not arrive within %0d cycles",
                 CYCLES_PER_WORD * prog_len);
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// File: testbench/cpu_stimulus.mem
// Words from 0: program image, one instruction per line
// Words from 0x100: program length, store count, store address and data, fetches, memory requests
@000
3C011234  // lui   $1, 0x1234
34215678  // ori   $1, $1, 0x5678
24030100  // addiu $3, $0, 0x100
2402FFFD  // addiu $2, $0, -3
00412023  // subu  $4, $2, $1
AC640000  // sw    $4, 0($3)
00202827  // nor   $5, $1, $0
38A500FF  // xori  $5, $5, 0xff
AC650004  // sw    $5, 4($3)
00023043  // sra   $6, $2, 1
00013902  // srl   $7, $1, 4
00C73026  // xor   $6, $6, $7
AC660008  // sw    $6, 8($3)
00013A00  // sll   $7, $1, 8
0040402A  // slt   $8, $2, $0
0002482B  // sltu  $9, $0, $2
284AFFFE  // slti  $10, $2, -2
304BFFF0  // andi  $11, $2, 0xfff0
00E86021  // addu  $12, $7, $8
01896021  // addu  $12, $12, $9
018A6021  // addu  $12, $12, $10
018B6026  // xor   $12, $12, $11
AC6C000C  // sw    $12, 12($3)
00856824  // and   $13, $4, $5
01A86825  // or    $13, $13, $8
AC6D0010  // sw    $13, 16($3)
AC610014  // sw    $1, 20($3)
8C6E0014  // lw    $14, 20($3)
25CF0010  // addiu $15, $14, 0x10
AC6F0018  // sw    $15, 24($3)
11C10001  // beq   $14, $1, +1 (taken)
AC60001C  // sw    $0, 28($3) poison
15C10001  // bne   $14, $1, +1 (not taken)
AC62001C  // sw    $2, 28($3)
08000024  // j     0x90
AC600020  // sw    $0, 32($3) poison
0C000028  // jal   0xa0, links 0x98
AC600020  // sw    $0, 32($3) poison
AC7F0020  // sw    $31, 32($3)
0800002A  // j     0xa8
00000000  // nop
03E00008  // jr    $31
8C700000  // lw    $16, 0($3)
AC700024  // sw    $16, 36($3), final store
1000FFFF  // beq   $0, $0, -1
@100
0000002D  // program length
0000000A  // store count
00000100 EDCBA985  // subu
00000104 EDCBA978  // nor, xori
00000108 FEDCBA99  // sra, srl, xor
0000010C 345687F3  // sll, slt, sltu, slti, andi, addu
00000110 EDCBA901  // and, or
00000114 12345678  // store before load
00000118 12345688  // load then use
0000011C FFFFFFFD  // branch path
00000120 00000098  // jal return address
00000124 EDCBA985  // reload of the first store
00000029  // fetches at the final store
0000000C  // memory requests at the final store

// File: verilog.f
+incdir+hw
hw/cpu_pkg.sv
hw/cpu_alu.sv
hw/cpu_reg_file.sv
hw/cpu_decode.sv
hw/cpu_control.sv
hw/cpu_datapath.sv
hw/cpu_perf_counters.sv
hw/cpu_top.sv
testbench/tb_cpu_top.sv

// File: Makefile
VERILATOR := verilator
TOP       := tb_cpu_top
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# A $fatal in the testbench gives a nonzero exit status
run: compile
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
